//--- Makefile
TOP := tb_cart_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP) | awk '{ print } /^TEST OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- cart_bus_ctrl.sv
`timescale 1ns/1ps

module cart_bus_ctrl
  import cart_pkg::*;
(
  input  logic        CLK,
  input  logic        rst,
  input  logic        req_valid,
  input  logic        dec_valid,
  input  map_result_t map_res,
  input  reg_hits_t   hits,
  output logic        busy,
  output logic        wb_cyc,
  output logic        wb_stb,
  output logic        wb_we,
  output logic [23:0] wb_adr,
  output logic [7:0]  wb_dat_w,
  input  logic [7:0]  wb_dat_r,
  input  logic        wb_ack,
  output cart_resp_t  resp
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_DEC,
    S_BUS,
    S_RESP
  } state_t;

  state_t      state;
  map_result_t map_q;
  reg_hits_t   hits_q;
  logic [7:0]  rdata_q;
  logic        mem_hit;

  assign mem_hit = map_res.is_rom | map_res.is_saveram;

  ////////////////////////////////////////////////////////////
  // Request FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (rst) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: if (req_valid) state <= S_DEC;
        // Decoders answer one cycle after acceptance
        S_DEC:  if (dec_valid) state <= mem_hit ? S_BUS : S_RESP;
        // Hold until the slave acks
        S_BUS:  if (wb_ack) state <= S_RESP;
        S_RESP: state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // Latch decode result, read data at ack
  always_ff @(posedge CLK) begin
    if (state == S_DEC && dec_valid) begin
      map_q   <= map_res;
      hits_q  <= hits;
      rdata_q <= 8'h00;
    end else if (state == S_BUS && wb_ack) begin
      rdata_q <= wb_dat_r;
    end
  end

  ////////////////////////////////////////////////////////////
  // Wishbone master and response
  ////////////////////////////////////////////////////////////
  assign busy     = (state != S_IDLE);
  assign wb_cyc   = (state == S_BUS);
  assign wb_stb   = (state == S_BUS);
  // Address and data come from the held copy
  assign wb_we    = map_q.we;
  assign wb_adr   = map_q.psram_addr;
  assign wb_dat_w = map_q.wdata;

  always_comb begin
    resp.valid      = (state == S_RESP);
    resp.rdata      = rdata_q;
    resp.is_rom     = map_q.is_rom;
    resp.is_saveram = map_q.is_saveram;
    resp.hits       = hits_q;
  end

  ap_stb_cyc: assert property (@(posedge CLK) disable iff (rst) wb_stb |-> wb_cyc);

  // Cycle attributes frozen through wait states
  ap_wb_hold: assert property (@(posedge CLK) disable iff (rst)
    (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_we)
                             && $stable(wb_dat_w)));

  // Decoder strobe only while waiting for it
  ap_dec_state: assert property (@(posedge CLK) disable iff (rst)
    dec_valid |-> (state == S_DEC));

endmodule

//--- cart_map_decode.sv
`timescale 1ns/1ps

module cart_map_decode
  import cart_pkg::*;
(
  input  logic        CLK,
  input  logic        rst,
  input  snes_req_t   req,
  input  cart_cfg_t   cfg,
  output logic        dec_valid,
  output map_result_t map_res
);

  snes_addr_u  a;
  logic        is_rom;
  logic        sram_win;
  logic        is_saveram;
  logic [23:0] psram_addr;
  logic [14:0] il_off;
  logic [23:0] sram_hi;
  logic [23:0] sram_lo;
  logic [23:0] sram_ex;
  logic [23:0] sram_il;

  assign a = req.addr;

  ////////////////////////////////////////////////////////////
  // Classification
  ////////////////////////////////////////////////////////////
  // Upper half of banks 00-3F/80-BF, or banks 40-FF with ROMSEL low
  // ROMSEL keeps WRAM banks 7E-7F out
  assign is_rom = (~a.raw[22] & a.fields.offset[15]) | (a.raw[22] & ~req.romsel_n);

  always_comb begin
    if (cfg.features[FEAT_ST0010]) begin
      // ST0010 window, banks 68-6F/E8-EF offset 0800-0FFF
      sram_win = (a.raw[22:19] == 4'b1101) & (a.fields.offset[15:12] == 4'h0)
               & a.fields.offset[11];
    end else begin
      case (cfg.mapper)
        // Banks 20-3F/A0-BF at 6000-7FFF
        MAP_HIROM, MAP_EXHIROM, MAP_INTERLEAVED:
          sram_win = ~a.raw[22] & a.raw[21] & (a.fields.offset[15:13] == 3'b011);
        // Banks 70-77 at 6000-7FFF
        MAP_EXLOROM:
          sram_win = (a.raw[23:19] == 5'b01110) & (a.fields.offset[15:13] == 3'b011);
        // Banks 70-7D/F0-FF; lower half only once ROM reaches 32 Mbit
        MAP_LOROM:
          sram_win = (&a.raw[22:20]) & ~req.romsel_n
                   & (~a.fields.offset[15] | ~cfg.rom_mask[21]);
        // Whole banks F0-FF
        MAP_MENU:
          sram_win = &a.raw[23:20];
        default:
          sram_win = 1'b0;
      endcase
    end
  end

  // No save RAM at all when mask bit 0 is clear
  assign is_saveram = cfg.saveram_mask[0] & sram_win;

  ////////////////////////////////////////////////////////////
  // PSRAM address translation
  ////////////////////////////////////////////////////////////
  // Save RAM offsets before masking
  assign sram_hi = {6'b0, a.fields.bank[4:0], a.fields.offset[12:0]};
  assign sram_lo = {4'b0, a.fields.bank[4:0], a.fields.offset[14:0]};
  assign sram_ex = {7'b0, a.fields.bank[3:0], a.fields.offset[12:0]};
  // Interleaved window starts at 6000
  assign il_off  = a.fields.offset[14:0] - 15'h6000;
  assign sram_il = {9'b0, il_off};

  always_comb begin
    case (cfg.mapper)
      MAP_HIROM: begin
        psram_addr = is_saveram ? SAVERAM_BASE + (sram_hi & cfg.saveram_mask)
                                : ({1'b0, a.raw[22:0]} & cfg.rom_mask);
      end
      MAP_LOROM: begin
        // 32 KiB pages, bank bit 23 inverted to fold the mirror
        psram_addr = is_saveram ? SAVERAM_BASE + (sram_lo & cfg.saveram_mask)
                                : ({1'b0, ~a.raw[23], a.raw[22:16], a.fields.offset[14:0]}
                                   & cfg.rom_mask);
      end
      MAP_EXHIROM, MAP_EXLOROM: begin
        psram_addr = is_saveram ? SAVERAM_BASE + (sram_ex & cfg.saveram_mask)
                                : ({1'b0, ~a.raw[23], a.raw[21:0]} & cfg.rom_mask);
      end
      MAP_INTERLEAVED: begin
        // 96 Mbit image, unmasked
        if (is_saveram) begin
          psram_addr = SAVERAM_BASE + (sram_il & cfg.saveram_mask);
        end else if (a.fields.offset[15]) begin
          psram_addr = {1'b0, a.raw[23:16], a.fields.offset[14:0]};
        end else begin
          psram_addr = {2'b10, a.raw[23], a.raw[21:16], a.fields.offset[14:0]};
        end
      end
      MAP_MENU: begin
        // Menu ROM sits in upper PSRAM
        psram_addr = is_saveram ? a.raw
                                : (({1'b0, a.raw[22:0]} & cfg.rom_mask) + MENU_ROM_BASE);
      end
      default: begin
        psram_addr = 24'h000000;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Output stage
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= req.valid;
    end
  end

  // Result follows the request by one edge
  always_ff @(posedge CLK) begin
    map_res.is_rom     <= is_rom;
    map_res.is_saveram <= is_saveram;
    map_res.psram_addr <= psram_addr;
    map_res.we         <= req.we;
    map_res.wdata      <= req.wdata;
  end

  // Registered save RAM hit only with mask bit 0 set at capture
  ap_saveram_mask: assert property (@(posedge CLK) disable iff (rst)
    map_res.is_saveram |-> $past(cfg.saveram_mask[0]));

endmodule

//--- cart_pkg.sv
package cart_pkg;

  ////////////////////////////////////////////////////////////
  // Mapper codes as reported by the MCU
  ////////////////////////////////////////////////////////////
  localparam logic [2:0] MAP_HIROM       = 3'd0;
  localparam logic [2:0] MAP_LOROM       = 3'd1;
  localparam logic [2:0] MAP_EXHIROM     = 3'd2;
  localparam logic [2:0] MAP_EXLOROM     = 3'd4;
  localparam logic [2:0] MAP_INTERLEAVED = 3'd6;
  localparam logic [2:0] MAP_MENU        = 3'd7;

  // Bit positions in the feature word
  localparam int FEAT_ST0010 = 1;
  localparam int FEAT_MSU1   = 3;
  localparam int FEAT_213F   = 4;

  // PSRAM layout
  localparam logic [23:0] SAVERAM_BASE  = 24'hE00000;
  localparam logic [23:0] MENU_ROM_BASE = 24'hC00000;

  // Command region hooks, exact console addresses
  localparam logic [23:0] NMICMD_ADDR        = 24'h002BF2;
  localparam logic [23:0] RETURN_VECTOR_ADDR = 24'h002A6C;
  localparam logic [23:0] BRANCH1_ADDR       = 24'h002A1F;
  localparam logic [23:0] BRANCH2_ADDR       = 24'h002A59;
  localparam logic [23:0] BRANCH3_ADDR       = 24'h002A5E;

  ////////////////////////////////////////////////////////////
  // Bus types
  ////////////////////////////////////////////////////////////
  // Console address, flat or as bank:offset
  typedef union packed {
    logic [23:0] raw;
    struct packed {
      logic [7:0]  bank;
      logic [15:0] offset;
    } fields;
  } snes_addr_u;

  typedef struct packed {
    logic [2:0]  mapper;
    logic [15:0] features;
    logic [23:0] rom_mask;
    logic [23:0] saveram_mask;
  } cart_cfg_t;

  typedef struct packed {
    logic       valid;
    snes_addr_u addr;
    logic [7:0] pa;
    logic       romsel_n;
    logic       we;
    logic [7:0] wdata;
  } snes_req_t;

  typedef struct packed {
    logic        is_rom;
    logic        is_saveram;
    logic [23:0] psram_addr;
    logic        we;
    logic [7:0]  wdata;
  } map_result_t;

  typedef struct packed {
    logic msu;
    logic r213f;
    logic r2100;
    logic snescmd;
    logic nmicmd;
    logic return_vector;
    logic branch1;
    logic branch2;
    logic branch3;
  } reg_hits_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] rdata;
    logic       is_rom;
    logic       is_saveram;
    reg_hits_t  hits;
  } cart_resp_t;

endpackage

//--- cart_reg_decode.sv
`timescale 1ns/1ps

module cart_reg_decode
  import cart_pkg::*;
(
  input  logic        CLK,
  input  logic        rst,
  input  snes_req_t   req,
  input  logic [15:0] features,
  output reg_hits_t   hits
);

  reg_hits_t hits_d;

  ////////////////////////////////////////////////////////////
  // Select decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    // MSU registers at 2000-2007 in system banks
    hits_d.msu = features[FEAT_MSU1] & ~req.addr.raw[22]
               & ((req.addr.fields.offset & 16'hFFF8) == 16'h2000);
    // B-bus peripherals
    hits_d.r213f = features[FEAT_213F] & (req.pa == 8'h3F);
    hits_d.r2100 = (req.pa == 8'h00);
    // Command region 2A00-2BFF, system banks only
    hits_d.snescmd = ({req.addr.raw[22], req.addr.fields.offset[15:9]} == 8'b0_0010101);
    // Exact hook addresses
    hits_d.nmicmd        = (req.addr.raw == NMICMD_ADDR);
    hits_d.return_vector = (req.addr.raw == RETURN_VECTOR_ADDR);
    hits_d.branch1       = (req.addr.raw == BRANCH1_ADDR);
    hits_d.branch2       = (req.addr.raw == BRANCH2_ADDR);
    hits_d.branch3       = (req.addr.raw == BRANCH3_ADDR);
  end

  // Aligned with the map decoder output
  always_ff @(posedge CLK) begin
    if (rst) begin
      hits <= '0;
    end else begin
      hits <= hits_d;
    end
  end

endmodule

//--- cart_top.sv
`timescale 1ns/1ps

module cart_top
  import cart_pkg::*;
(
  input  logic        CLK,
  input  logic        rst,
  input  cart_cfg_t   cfg,
  input  snes_req_t   req,
  output logic        busy,
  output cart_resp_t  resp,
  output logic        wb_cyc,
  output logic        wb_stb,
  output logic        wb_we,
  output logic [23:0] wb_adr,
  output logic [7:0]  wb_dat_w,
  input  logic [7:0]  wb_dat_r,
  input  logic        wb_ack
);

  snes_req_t   req_acc;
  logic        dec_valid;
  map_result_t map_res;
  reg_hits_t   hits;

  // Requests during busy are dropped here
  always_comb begin
    req_acc       = req;
    req_acc.valid = req.valid & ~busy;
  end

  ////////////////////////////////////////////////////////////
  // Decoders side by side, controller behind them
  ////////////////////////////////////////////////////////////
  cart_map_decode map_decode_i (
    .CLK       (CLK),
    .rst       (rst),
    .req       (req_acc),
    .cfg       (cfg),
    .dec_valid (dec_valid),
    .map_res   (map_res)
  );

  cart_reg_decode reg_decode_i (
    .CLK      (CLK),
    .rst      (rst),
    .req      (req_acc),
    .features (cfg.features),
    .hits     (hits)
  );

  cart_bus_ctrl bus_ctrl_i (
    .CLK       (CLK),
    .rst       (rst),
    .req_valid (req_acc.valid),
    .dec_valid (dec_valid),
    .map_res   (map_res),
    .hits      (hits),
    .busy      (busy),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .resp      (resp)
  );

endmodule

//--- list.f
cart_pkg.sv
cart_map_decode.sv
cart_reg_decode.sv
cart_bus_ctrl.sv
cart_top.sv
tb_cart_top.sv

//--- tb_cart_top.sv
`timescale 1ns/1ps

module tb_cart_top
  import cart_pkg::*;
;

  localparam int RESET_CYCLES = 5;
  localparam int N_ROM  = 6;
  localparam int N_SAVE = 4;
  localparam int N_WR   = 12;
  localparam int N_MIX  = 60;
  localparam int N_REQ  = 18 * N_ROM + 18 * N_SAVE + 2 * N_WR + N_MIX;

  localparam logic [2:0] MAPPERS [6] = '{MAP_HIROM, MAP_LOROM, MAP_EXHIROM,
                                         MAP_EXLOROM, MAP_INTERLEAVED, MAP_MENU};
  // 8, 32 and 64 Mbit images
  localparam logic [23:0] ROM_MASKS [3] = '{24'h0FFFFF, 24'h3FFFFF, 24'h7FFFFF};
  localparam logic [23:0] CMD_ADDRS [5] = '{NMICMD_ADDR, RETURN_VECTOR_ADDR,
                                            BRANCH1_ADDR, BRANCH2_ADDR, BRANCH3_ADDR};

  typedef struct packed {
    map_result_t m;
    reg_hits_t   h;
  } expect_t;

  logic        CLK;
  logic        rst;
  cart_cfg_t   cfg;
  snes_req_t   req;
  logic        busy;
  cart_resp_t  resp;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [23:0] wb_adr;
  logic [7:0]  wb_dat_w;
  logic [7:0]  wb_dat_r = 8'h00;
  logic        wb_ack = 1'b0;

  logic [31:0] lfsr = 32'h28b9b44d;
  logic [1:0]  wait_cfg = 2'd0;
  logic [1:0]  wait_cnt = 2'd0;
  int          wr_count = 0;
  int          issued = 0;
  int          accepted = 0;
  int          responses = 0;
  int          writes_exp = 0;
  logic        cycle_seen = 1'b0;
  expect_t     exp_q[$];

  cart_top cart_top_i (
    .CLK      (CLK),
    .rst      (rst),
    .cfg      (cfg),
    .req      (req),
    .busy     (busy),
    .resp     (resp),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // Random address inside a mapper's save window, or the ST0010 one
  function automatic logic [23:0] window_addr(input logic [2:0] mapper, input logic st);
    logic [23:0] r;
    r = 24'(take_bits(24));
    if (st) begin
      r = {r[23], 4'b1101, r[18:16], 5'b00001, r[10:0]};
    end else begin
      case (mapper)
        MAP_LOROM:   r = {r[23], 3'b111, r[19:16], 1'b0, r[14:0]};
        MAP_EXLOROM: r = {5'b01110, r[18:16], 3'b011, r[12:0]};
        MAP_MENU:    r = {4'hF, r[19:0]};
        default:     r = {r[23], 2'b01, r[20:16], 3'b011, r[12:0]};
      endcase
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model of both decoders
  ////////////////////////////////////////////////////////////
  function automatic expect_t expected_decode(input cart_cfg_t c, input snes_req_t r);
    expect_t     e;
    logic [23:0] raw;
    logic [7:0]  bank;
    logic [15:0] off;
    logic        win;
    logic [23:0] sram_off;
    logic [23:0] rom_adr;
    raw  = r.addr.raw;
    bank = raw[23:16];
    off  = raw[15:0];
    e    = '0;
    e.m.we     = r.we;
    e.m.wdata  = r.wdata;
    e.m.is_rom = bank[6] ? !r.romsel_n : (off >= 16'h8000);
    // Save windows
    if (c.features[FEAT_ST0010]) begin
      win = ((bank & 8'h78) == 8'h68) && (off >= 16'h0800) && (off < 16'h1000);
    end else if (c.mapper == MAP_LOROM) begin
      win = ((bank & 8'h70) == 8'h70) && !r.romsel_n
            && (off < 16'h8000 || !c.rom_mask[21]);
    end else if (c.mapper == MAP_EXLOROM) begin
      win = (bank >= 8'h70) && (bank <= 8'h77) && (off >= 16'h6000) && (off < 16'h8000);
    end else if (c.mapper == MAP_MENU) begin
      win = (bank >= 8'hF0);
    end else begin
      win = ((bank & 8'h60) == 8'h20) && (off >= 16'h6000) && (off < 16'h8000);
    end
    e.m.is_saveram = win && c.saveram_mask[0];
    case (c.mapper)
      MAP_LOROM:   sram_off = (24'(bank & 8'h1F) << 15) | 24'(off & 16'h7FFF);
      MAP_EXHIROM,
      MAP_EXLOROM: sram_off = (24'(bank & 8'h0F) << 13) | 24'(off & 16'h1FFF);
      MAP_INTERLEAVED: sram_off = 24'((off - 16'h6000) & 16'h7FFF);
      default:     sram_off = (24'(bank & 8'h1F) << 13) | 24'(off & 16'h1FFF);
    endcase
    // ROM folding per mapper
    case (c.mapper)
      MAP_LOROM: begin
        rom_adr = ((24'(bank ^ 8'h80) << 15) | 24'(off & 16'h7FFF)) & c.rom_mask;
      end
      MAP_EXHIROM, MAP_EXLOROM: begin
        rom_adr = ((raw & 24'h3FFFFF) | (raw[23] ? 24'h0 : 24'h400000)) & c.rom_mask;
      end
      MAP_INTERLEAVED: begin
        if (off[15]) begin
          rom_adr = (24'(bank) << 15) | 24'(off & 16'h7FFF);
        end else begin
          rom_adr = 24'h800000 | (raw[23] ? 24'h200000 : 24'h0)
                  | (24'(bank & 8'h3F) << 15) | 24'(off & 16'h7FFF);
        end
      end
      MAP_MENU: rom_adr = (raw & 24'h7FFFFF & c.rom_mask) + MENU_ROM_BASE;
      default:  rom_adr = raw & 24'h7FFFFF & c.rom_mask;
    endcase
    if (!e.m.is_saveram) begin
      e.m.psram_addr = rom_adr;
    end else if (c.mapper == MAP_MENU) begin
      e.m.psram_addr = raw;
    end else begin
      e.m.psram_addr = SAVERAM_BASE + (sram_off & c.saveram_mask);
    end
    // Register selects
    e.h.msu     = c.features[FEAT_MSU1] && !bank[6] && off >= 16'h2000 && off <= 16'h2007;
    e.h.r213f   = c.features[FEAT_213F] && (r.pa == 8'h3F);
    e.h.r2100   = (r.pa == 8'h00);
    e.h.snescmd = !bank[6] && off >= 16'h2A00 && off <= 16'h2BFF;
    e.h.nmicmd        = (raw == NMICMD_ADDR);
    e.h.return_vector = (raw == RETURN_VECTOR_ADDR);
    e.h.branch1       = (raw == BRANCH1_ADDR);
    e.h.branch2       = (raw == BRANCH2_ADDR);
    e.h.branch3       = (raw == BRANCH3_ADDR);
    return e;
  endfunction

  ////////////////////////////////////////////////////////////
  // PSRAM slave, 0 to 3 wait states
  ////////////////////////////////////////////////////////////
  always @(posedge CLK) begin
    if (rst) begin
      wb_ack   <= 1'b0;
      wait_cnt <= 2'd0;
    end else if (wb_stb && !wb_ack) begin
      if (wait_cnt == wait_cfg) begin
        wb_ack   <= 1'b1;
        // Data is a function of the address
        wb_dat_r <= wb_adr[7:0] ^ wb_adr[23:16];
        wait_cnt <= 2'd0;
        if (wb_we) begin
          wr_count <= wr_count + 1;
        end
      end else begin
        wait_cnt <= wait_cnt + 2'd1;
      end
    end else begin
      wb_ack <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare, sampled mid-cycle
  ////////////////////////////////////////////////////////////
  always @(negedge CLK) begin
    expect_t    e;
    logic       mem;
    logic       pending;
    logic [7:0] exp_rdata;
    if (!rst) begin
      pending = (exp_q.size() != 0);
      // Busy exactly while an accepted request is outstanding
      assert (busy == pending)
        else report_mismatch("busy", 32'(pending), 32'(busy));
      // Cycle and strobe rise and fall together
      assert (wb_cyc == wb_stb)
        else report_mismatch("wb_cyc", 32'(wb_stb), 32'(wb_cyc));
      if (wb_stb) begin
        if (!pending || !(exp_q[0].m.is_rom || exp_q[0].m.is_saveram)) begin
          abort_run("Wishbone cycle started without an expected memory hit");
        end else if (cycle_seen) begin
          abort_run("Wishbone strobe stayed high after the ack");
        end else if (wb_ack) begin
          e = exp_q[0];
          assert (wb_adr == e.m.psram_addr)
            else report_mismatch("wb_adr", 32'(e.m.psram_addr), 32'(wb_adr));
          assert (wb_we == e.m.we) else report_mismatch("wb_we", 32'(e.m.we), 32'(wb_we));
          assert (wb_dat_w == e.m.wdata)
            else report_mismatch("wb_dat_w", 32'(e.m.wdata), 32'(wb_dat_w));
          cycle_seen = 1'b1;
        end
      end
      if (resp.valid) begin
        if (exp_q.size() == 0) begin
          abort_run("Response came without a preceding accepted request");
        end else begin
          e   = exp_q.pop_front();
          mem = e.m.is_rom || e.m.is_saveram;
          if (mem && !cycle_seen) begin
            abort_run("Memory hit answered without a Wishbone cycle");
          end else begin
            exp_rdata = mem ? (e.m.psram_addr[7:0] ^ e.m.psram_addr[23:16]) : 8'h00;
            assert (resp.rdata == exp_rdata)
              else report_mismatch("resp.rdata", 32'(exp_rdata), 32'(resp.rdata));
            assert (resp.is_rom == e.m.is_rom)
              else report_mismatch("resp.is_rom", 32'(e.m.is_rom), 32'(resp.is_rom));
            assert (resp.is_saveram == e.m.is_saveram)
              else report_mismatch("resp.is_saveram", 32'(e.m.is_saveram),
                                   32'(resp.is_saveram));
            assert (resp.hits == e.h)
              else report_mismatch("resp.hits", 32'(e.h), 32'(resp.hits));
            if (mem && e.m.we) begin
              writes_exp++;
            end
            cycle_seen = 1'b0;
            responses++;
          end
        end
      end
      // Accepted at the coming edge
      if (req.valid && !pending) begin
        exp_q.push_back(expected_decode(cfg, req));
        accepted++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  task automatic load_config(input logic [2:0] mapper, input logic [15:0] features,
                             input logic [23:0] rom_mask, input logic [23:0] sram_mask);
    cart_cfg_t c;
    c.mapper       = mapper;
    c.features     = features;
    c.rom_mask     = rom_mask;
    c.saveram_mask = sram_mask;
    @(posedge CLK);
    cfg <= c;
  endtask

  // One request, then wait for its response
  // With noise, fresh requests are driven all through busy
  task automatic send_request(input logic [23:0] addr, input logic [7:0] pa,
                              input logic romsel_n, input logic we,
                              input logic [7:0] wdata, input logic noise);
    snes_req_t r;
    logic      done;
    r.valid    = 1'b1;
    r.addr.raw = addr;
    r.pa       = pa;
    r.romsel_n = romsel_n;
    r.we       = we;
    r.wdata    = wdata;
    @(negedge CLK);
    while (busy) @(negedge CLK);
    @(posedge CLK);
    req      <= r;
    wait_cfg <= 2'(take_bits(2));
    issued++;
    @(posedge CLK);
    do begin
      if (noise) begin
        r.addr.raw = 24'(take_bits(24));
        r.pa       = 8'(take_bits(8));
        req <= r;
      end else begin
        req.valid <= 1'b0;
      end
      @(negedge CLK);
      done = resp.valid;
      @(posedge CLK);
    end while (!done);
    req.valid <= 1'b0;
  endtask

  initial begin
    logic [23:0] a;
    logic [7:0]  pa;
    logic [7:0]  d;
    logic        rs;
    logic        we;
    logic [2:0]  m;
    int          sel;
    rst = 1'b1;
    cfg = '0;
    req = '0;

    // Quiet bus during reset and just after it
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge CLK);
      if (i == RESET_CYCLES - 1) begin
        rst <= 1'b0;
      end
      @(negedge CLK);
      assert (!busy && !wb_cyc && !wb_stb && !resp.valid)
        else abort_run("busy, Wishbone strobe or response was active around reset");
    end

    // ROM reads for every mapper and ROM size
    for (int i = 0; i < 6; i++) begin
      for (int k = 0; k < 3; k++) begin
        load_config(MAPPERS[i], 16'h0000, ROM_MASKS[k], 24'h001FFF);
        for (int n = 0; n < N_ROM; n++) begin
          a = 24'(take_bits(24));
          if (!a[22]) begin
            a[15] = 1'b1;
          end
          send_request(a, 8'hFF, 1'b0, 1'b0, 8'h00, 1'b0);
        end
      end
    end

    // Save windows, k 1 clears mask bit 0, k 2 enables ST0010
    for (int i = 0; i < 6; i++) begin
      for (int k = 0; k < 3; k++) begin
        load_config(MAPPERS[i], (k == 2) ? 16'h0002 : 16'h0000, 24'h3FFFFF,
                    (k == 1) ? 24'h00FFFE : 24'h00FFFF);
        for (int n = 0; n < N_SAVE; n++) begin
          a = window_addr(MAPPERS[i], (k == 2) && n[0]);
          send_request(a, 8'hFF, MAPPERS[i] != MAP_LOROM, 1'b0, 8'h00, 1'b0);
        end
      end
    end

    // Write then read back
    for (int n = 0; n < N_WR; n++) begin
      m = MAPPERS[n % 6];
      load_config(m, 16'h0000, 24'h3FFFFF, 24'h001FFF);
      a = window_addr(m, 1'b0);
      d = 8'(take_bits(8));
      send_request(a, 8'hFF, m != MAP_LOROM, 1'b1, d, 1'b0);
      send_request(a, 8'hFF, m != MAP_LOROM, 1'b0, 8'h00, 1'b0);
    end

    // Register selects, random config, requests while busy
    for (int n = 0; n < N_MIX; n++) begin
      load_config(MAPPERS[n % 6], 16'(take_bits(16)), ROM_MASKS[n % 3], 24'h001FFF);
      a   = 24'(take_bits(24));
      sel = int'(take_bits(2));
      case (sel)
        0: a = {a[23], 1'b0, a[21:16], 13'h0400, a[2:0]};
        1: a = {a[23], 1'b0, a[21:16], 7'b0010101, a[8:0]};
        2: a = CMD_ADDRS[int'(a[2:0]) % 5];
        default: ;
      endcase
      sel = int'(take_bits(2));
      pa  = (sel == 0) ? 8'h00 : (sel == 1) ? 8'h3F : 8'(take_bits(8));
      rs  = take_bits(1) != 0;
      we  = take_bits(1) != 0;
      d   = 8'(take_bits(8));
      send_request(a, pa, rs, we, d, 1'b1);
    end

    repeat (4) @(negedge CLK);
    if (responses == issued && accepted == issued && exp_q.size() == 0
        && wr_count == writes_exp) begin
      $display("TEST OK");
      $finish;
    end else begin
      abort_run("Request, response or write counts did not match");
    end
  end

  // Watchdog
  initial begin
    repeat (RESET_CYCLES + N_REQ * 16) @(posedge CLK);
    abort_run("Watchdog expired before all requests were answered");
  end

endmodule
